/* logic/mem_wb.sv */
`timescale 1ns/1ps

module mem_wb (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              master_clear,
    input  logic              slave_clear,
    input  logic              master_ena,
    input  logic              slave_ena,
    input  wb_pkg::wb_entry_t m_master,
    input  wb_pkg::wb_entry_t m_slave,
    output wb_pkg::wb_entry_t w_master,
    output wb_pkg::wb_entry_t w_slave
);

    localparam int NLANES = 2;

    // lane 0 is master (older), lane 1 is slave.
    logic [NLANES-1:0]  lane_clear;
    logic [NLANES-1:0]  lane_ena;
    wb_pkg::wb_entry_t  lane_d [NLANES];

    assign lane_clear = {slave_clear, master_clear};
    assign lane_ena   = {slave_ena, master_ena};
    assign lane_d[0]  = m_master;
    assign lane_d[1]  = m_slave;

    for (genvar i = 0; i < NLANES; i++) begin : g_lane
        wb_pkg::wb_entry_t q;

        // clear wins over enable, a cleared lane is a bubble.
        always_ff @(posedge clk) begin
            if (!rst_n || lane_clear[i]) begin
                q <= '0;
            end else if (lane_ena[i]) begin
                q <= lane_d[i];
            end
        end
    end

    assign w_master = g_lane[0].q;
    assign w_slave  = g_lane[1].q;

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps

`include "wb_cfg.svh"

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  wb_pkg::wr_req_t   wr0,
    input  wb_pkg::wr_req_t   wr1,
    input  wb_pkg::reg_addr_t rd_addr_a,
    input  wb_pkg::reg_addr_t rd_addr_b,
    output wb_pkg::word_t     rd_data_a,
    output wb_pkg::word_t     rd_data_b
);

    wb_pkg::word_t regs [`WB_NREGS];

    logic wr0_ok;
    logic wr1_ok;

    assign wr0_ok = wr0.wen && (wr0.waddr != '0);
    assign wr1_ok = wr1.wen && (wr1.waddr != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `WB_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr0_ok) begin
                regs[wr0.waddr] <= wr0.wdata;
            end
            // port 1 is the younger lane, listed last.
            if (wr1_ok) begin
                regs[wr1.waddr] <= wr1.wdata;
            end
        end
    end

    // combinational reads, r0 always zero.
    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

/* logic/wb_arbiter.sv */
`timescale 1ns/1ps

module wb_arbiter (
    input  wb_pkg::wr_req_t   master_wr,
    input  wb_pkg::wr_req_t   slave_wr,
    input  wb_pkg::exc_req_t  master_exc,
    input  wb_pkg::exc_req_t  slave_exc,
    output wb_pkg::wr_req_t   wr0,
    output wb_pkg::wr_req_t   wr1,
    output logic              exc_valid,
    output wb_pkg::exc_code_t exc_code,
    output wb_pkg::word_t     exc_pc
);

    wb_pkg::wr_req_t slave_live;
    logic            collide;

    // older exception squashes the younger lane.
    always_comb begin
        slave_live = slave_wr;
        if (master_exc.valid) begin
            slave_live.wen = 1'b0;
        end
    end

    assign collide = master_wr.wen && slave_live.wen &&
                     (master_wr.waddr == slave_live.waddr);

    // port 0 carries the master, port 1 the slave.
    always_comb begin
        wr0     = master_wr;
        wr0.wen = master_wr.wen && !collide;  // younger value wins.
        wr1     = slave_live;
    end

    // master exception first, slave's is only seen when master is clean.
    always_comb begin
        if (master_exc.valid) begin
            exc_valid = 1'b1;
            exc_code  = master_exc.code;
            exc_pc    = master_exc.pc;
        end else if (slave_exc.valid) begin
            exc_valid = 1'b1;
            exc_code  = slave_exc.code;
            exc_pc    = slave_exc.pc;
        end else begin
            exc_valid = 1'b0;
            exc_code  = '0;
            exc_pc    = '0;
        end
    end

endmodule

/* logic/wb_cfg.svh */
`ifndef WB_CFG_SVH
`define WB_CFG_SVH

// data, instruction and pc width.
`define WB_XLEN    32

// register index width.
`define WB_RADDR_W 5

// exception code width, zero code means no exception.
`define WB_EXC_W   8

// architectural register count, entry zero is hardwired.
`define WB_NREGS   32

`endif

/* logic/wb_lane_gate.sv */
`timescale 1ns/1ps

module wb_lane_gate (
    input  wb_pkg::wb_entry_t entry,
    output wb_pkg::wr_req_t   wr,
    output wb_pkg::exc_req_t  exc
);

    logic has_exc;
    logic to_zero;

    assign has_exc = (entry.except != '0);
    assign to_zero = (entry.reg_waddr == '0);

    // an excepting instruction must not touch the register file.
    assign wr.wen   = entry.reg_wen && !to_zero && !has_exc;
    assign wr.waddr = entry.reg_waddr;
    assign wr.wdata = entry.reg_wdata;

    assign exc.valid = has_exc;
    assign exc.code  = entry.except;
    assign exc.pc    = entry.pc;

endmodule

/* logic/wb_pkg.sv */
`include "wb_cfg.svh"

package wb_pkg;

    typedef logic [`WB_XLEN-1:0]    word_t;
    typedef logic [`WB_RADDR_W-1:0] reg_addr_t;
    typedef logic [`WB_EXC_W-1:0]   exc_code_t;

    // one instruction as it leaves the memory stage.
    typedef struct packed {
        logic      reg_wen;
        reg_addr_t reg_waddr;
        exc_code_t except;
        word_t     inst;
        word_t     pc;
        word_t     reg_wdata;
    } wb_entry_t;

    // register file write port.
    typedef struct packed {
        logic      wen;
        reg_addr_t waddr;
        word_t     wdata;
    } wr_req_t;

    // exception raised by one lane.
    typedef struct packed {
        logic      valid;
        exc_code_t code;
        word_t     pc;  // pc of the faulting instruction.
    } exc_req_t;

endpackage

/* logic/wb_top.sv */
`timescale 1ns/1ps

module wb_top (
    input  logic              clk,
    input  logic              rst_n,
    input  wb_pkg::wb_entry_t m_master,
    input  wb_pkg::wb_entry_t m_slave,
    input  logic              master_clear,
    input  logic              slave_clear,
    input  logic              master_ena,
    input  logic              slave_ena,
    input  wb_pkg::reg_addr_t rd_addr_a,
    input  wb_pkg::reg_addr_t rd_addr_b,
    output wb_pkg::word_t     rd_data_a,
    output wb_pkg::word_t     rd_data_b,
    output logic              exc_valid,
    output wb_pkg::exc_code_t exc_code,
    output wb_pkg::word_t     exc_pc
);

    wb_pkg::wb_entry_t w_master;
    wb_pkg::wb_entry_t w_slave;
    wb_pkg::wr_req_t   master_wr;
    wb_pkg::wr_req_t   slave_wr;
    wb_pkg::exc_req_t  master_exc;
    wb_pkg::exc_req_t  slave_exc;
    wb_pkg::wr_req_t   wr0;
    wb_pkg::wr_req_t   wr1;

    mem_wb i_mem_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .master_clear (master_clear),
        .slave_clear  (slave_clear),
        .master_ena   (master_ena),
        .slave_ena    (slave_ena),
        .m_master     (m_master),
        .m_slave      (m_slave),
        .w_master     (w_master),
        .w_slave      (w_slave)
    );

    wb_lane_gate i_master_gate (
        .entry (w_master),
        .wr    (master_wr),
        .exc   (master_exc)
    );

    wb_lane_gate i_slave_gate (
        .entry (w_slave),
        .wr    (slave_wr),
        .exc   (slave_exc)
    );

    wb_arbiter i_arbiter (
        .master_wr  (master_wr),
        .slave_wr   (slave_wr),
        .master_exc (master_exc),
        .slave_exc  (slave_exc),
        .wr0        (wr0),
        .wr1        (wr1),
        .exc_valid  (exc_valid),
        .exc_code   (exc_code),
        .exc_pc     (exc_pc)
    );

    reg_file i_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr0       (wr0),
        .wr1       (wr1),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

endmodule

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f sources.f --top-module wb_tb \
    -o wb_sim > build.log 2>&1 \
    && ./obj_dir/wb_sim > sim.log 2>&1
grep -qx "TEST PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* sources.f */
+incdir+logic
logic/wb_pkg.sv
logic/mem_wb.sv
logic/wb_lane_gate.sv
logic/wb_arbiter.sv
logic/reg_file.sv
logic/wb_top.sv
tb/wb_assert.sv
tb/wb_tb.sv

/* tb/wb_assert.sv */
`timescale 1ns/1ps

module wb_assert (
    input logic            clk,
    input logic            rst_n,
    input wb_pkg::wr_req_t wr0,
    input wb_pkg::wr_req_t wr1,
    input logic            master_exc_valid,
    input wb_pkg::word_t   r0
);

    int unsigned fail_count = 0;

    // the two write ports never target one register together.
    a_no_dup_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr0.wen && wr1.wen && (wr0.waddr == wr1.waddr)))
        else begin
            fail_count = fail_count + 1;
            $error("both write ports hit register %0d", wr0.waddr);
        end

    a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        r0 == '0)
        else begin
            fail_count = fail_count + 1;
            $error("register zero holds 0x%h", r0);
        end

    // older exception squashes the slave write.
    a_exc_squash: assert property (@(posedge clk) disable iff (!rst_n)
        master_exc_valid |-> !wr1.wen)
        else begin
            fail_count = fail_count + 1;
            $error("slave write passed a master exception");
        end

endmodule

// taps the arbiter write ports and register zero.
bind wb_top wb_assert i_assert (
    .clk              (clk),
    .rst_n            (rst_n),
    .wr0              (wr0),
    .wr1              (wr1),
    .master_exc_valid (master_exc.valid),
    .r0               (i_reg_file.regs[0])
);

/* tb/wb_tb.sv */
`timescale 1ns/1ps

`include "wb_cfg.svh"

module wb_tb;

    localparam int NROWS       = 13;
    localparam int CYCLE_LIMIT = NROWS * 4 + 50;

    // one step of stimulus and the exception report it must produce.
    typedef struct packed {
        wb_pkg::wb_entry_t master;
        wb_pkg::wb_entry_t slave;
        logic              master_clear;
        logic              slave_clear;
        logic              master_ena;
        logic              slave_ena;
        wb_pkg::reg_addr_t rd_a;
        wb_pkg::reg_addr_t rd_b;
        logic              exp_valid;
        wb_pkg::exc_code_t exp_code;
        wb_pkg::word_t     exp_pc;
    } row_t;

    logic              clk;
    logic              rst_n;
    wb_pkg::wb_entry_t m_master;
    wb_pkg::wb_entry_t m_slave;
    logic              master_clear;
    logic              slave_clear;
    logic              master_ena;
    logic              slave_ena;
    wb_pkg::reg_addr_t rd_addr_a;
    wb_pkg::reg_addr_t rd_addr_b;
    wb_pkg::word_t     rd_data_a;
    wb_pkg::word_t     rd_data_b;
    logic              exc_valid;
    wb_pkg::exc_code_t exc_code;
    wb_pkg::word_t     exc_pc;

    row_t              rows [NROWS];
    wb_pkg::word_t     model_regs [`WB_NREGS];
    wb_pkg::wb_entry_t model_m;  // stage contents as the model sees them.
    wb_pkg::wb_entry_t model_s;
    wb_pkg::word_t     rng_state = 32'd13588;
    int                cycles = 0;

    wb_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .m_master     (m_master),
        .m_slave      (m_slave),
        .master_clear (master_clear),
        .slave_clear  (slave_clear),
        .master_ena   (master_ena),
        .slave_ena    (slave_ena),
        .rd_addr_a    (rd_addr_a),
        .rd_addr_b    (rd_addr_b),
        .rd_data_a    (rd_data_a),
        .rd_data_b    (rd_data_b),
        .exc_valid    (exc_valid),
        .exc_code     (exc_code),
        .exc_pc       (exc_pc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the stimulus table did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $fatal(1, "run stopped by timeout");
        end
    end

    function automatic wb_pkg::word_t xorshift(input wb_pkg::word_t x);
        wb_pkg::word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic wb_pkg::word_t rand_word();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic wb_pkg::wb_entry_t ent(input logic wen, input wb_pkg::reg_addr_t addr,
                                              input wb_pkg::exc_code_t code,
                                              input wb_pkg::word_t pc);
        wb_pkg::wb_entry_t e;
        e.reg_wen   = wen;
        e.reg_waddr = addr;
        e.except    = code;
        e.inst      = 32'h0000_0013;
        e.pc        = pc;
        e.reg_wdata = rand_word();
        return e;
    endfunction

    task automatic check_word(input string name, input wb_pkg::word_t got,
                              input wb_pkg::word_t exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_code(input string name, input wb_pkg::exc_code_t got,
                              input wb_pkg::exc_code_t exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic build_table();
        // dual writes, register zero and a same-address pair.
        rows[0]  = '{ent(1'b1, 5'd1, 8'h00, 32'h1000), ent(1'b1, 5'd2, 8'h00, 32'h1004),
                     1'b0, 1'b0, 1'b1, 1'b1, 5'd1, 5'd2, 1'b0, 8'h00, 32'h0};
        rows[1]  = '{ent(1'b1, 5'd0, 8'h00, 32'h1008), ent(1'b1, 5'd3, 8'h00, 32'h100c),
                     1'b0, 1'b0, 1'b1, 1'b1, 5'd0, 5'd3, 1'b0, 8'h00, 32'h0};
        rows[2]  = '{ent(1'b1, 5'd5, 8'h00, 32'h1010), ent(1'b1, 5'd5, 8'h00, 32'h1014),
                     1'b0, 1'b0, 1'b1, 1'b1, 5'd5, 5'd5, 1'b0, 8'h00, 32'h0};
        rows[3]  = '{ent(1'b1, 5'd4, 8'h00, 32'h1018), ent(1'b1, 5'd0, 8'h00, 32'h101c),
                     1'b0, 1'b0, 1'b1, 1'b1, 5'd4, 5'd0, 1'b0, 8'h00, 32'h0};
        // exceptions in program order.
        rows[4]  = '{ent(1'b1, 5'd1, 8'h04, 32'h1020), ent(1'b1, 5'd2, 8'h00, 32'h1024),
                     1'b0, 1'b0, 1'b1, 1'b1, 5'd1, 5'd2, 1'b1, 8'h04, 32'h1020};
        rows[5]  = '{ent(1'b1, 5'd6, 8'h00, 32'h1028), ent(1'b1, 5'd7, 8'h0c, 32'h102c),
                     1'b0, 1'b0, 1'b1, 1'b1, 5'd6, 5'd7, 1'b1, 8'h0c, 32'h102c};
        rows[6]  = '{ent(1'b0, 5'd0, 8'h08, 32'h2000), ent(1'b1, 5'd3, 8'h0a, 32'h2004),
                     1'b0, 1'b0, 1'b1, 1'b1, 5'd3, 5'd0, 1'b1, 8'h08, 32'h2000};
        // clears turn a lane into a bubble.
        rows[7]  = '{ent(1'b1, 5'd8, 8'h04, 32'h2008), ent(1'b1, 5'd9, 8'h00, 32'h200c),
                     1'b1, 1'b0, 1'b1, 1'b1, 5'd8, 5'd9, 1'b0, 8'h00, 32'h0};
        rows[8]  = '{ent(1'b1, 5'd10, 8'h00, 32'h2010), ent(1'b1, 5'd11, 8'h0d, 32'h2014),
                     1'b0, 1'b1, 1'b1, 1'b1, 5'd10, 5'd11, 1'b0, 8'h00, 32'h0};
        // stalls hold the previous entries.
        rows[9]  = '{ent(1'b1, 5'd11, 8'h06, 32'h2018), ent(1'b1, 5'd12, 8'h00, 32'h201c),
                     1'b0, 1'b0, 1'b0, 1'b0, 5'd10, 5'd12, 1'b0, 8'h00, 32'h0};
        rows[10] = '{ent(1'b1, 5'd12, 8'h00, 32'h2020), ent(1'b1, 5'd13, 8'h00, 32'h2024),
                     1'b0, 1'b0, 1'b1, 1'b0, 5'd12, 5'd13, 1'b0, 8'h00, 32'h0};
        rows[11] = '{ent(1'b1, 5'd14, 8'h00, 32'h2028), ent(1'b1, 5'd15, 8'h00, 32'h202c),
                     1'b1, 1'b1, 1'b1, 1'b1, 5'd14, 5'd15, 1'b0, 8'h00, 32'h0};
        rows[12] = '{ent(1'b1, 5'd17, 8'h00, 32'h2030), ent(1'b1, 5'd16, 8'h00, 32'h2034),
                     1'b0, 1'b0, 1'b0, 1'b1, 5'd17, 5'd16, 1'b0, 8'h00, 32'h0};
    endtask

    task automatic update_stage(input row_t row);
        if (row.master_clear) begin
            model_m = '0;
        end else if (row.master_ena) begin
            model_m = row.master;
        end
        if (row.slave_clear) begin
            model_s = '0;
        end else if (row.slave_ena) begin
            model_s = row.slave;
        end
    endtask

    task automatic commit_writes();
        logic m_ok;
        logic s_ok;
        m_ok = model_m.reg_wen && (model_m.reg_waddr != '0) && (model_m.except == '0);
        s_ok = model_s.reg_wen && (model_s.reg_waddr != '0) && (model_s.except == '0)
               && (model_m.except == '0);
        if (m_ok) begin
            model_regs[model_m.reg_waddr] = model_m.reg_wdata;
        end
        if (s_ok) begin
            model_regs[model_s.reg_waddr] = model_s.reg_wdata;  // younger lane wins.
        end
    endtask

    task automatic check_reset();
        for (int i = 0; i < `WB_NREGS / 2; i++) begin
            @(posedge clk);
            rd_addr_a <= wb_pkg::reg_addr_t'(2 * i);
            rd_addr_b <= wb_pkg::reg_addr_t'(2 * i + 1);
            @(negedge clk);
            check_word("rd_data_a", rd_data_a, '0);
            check_word("rd_data_b", rd_data_b, '0);
            check_bit("exc_valid", exc_valid, 1'b0);
        end
    endtask

    task automatic run_row(input int idx);
        row_t row;
        row = rows[idx];
        @(posedge clk);
        m_master     <= row.master;
        m_slave      <= row.slave;
        master_clear <= row.master_clear;
        slave_clear  <= row.slave_clear;
        master_ena   <= row.master_ena;
        slave_ena    <= row.slave_ena;
        rd_addr_a    <= row.rd_a;
        rd_addr_b    <= row.rd_b;
        @(posedge clk);  // stage captures here.
        master_clear <= 1'b0;
        slave_clear  <= 1'b0;
        master_ena   <= 1'b0;
        slave_ena    <= 1'b0;
        update_stage(row);
        @(negedge clk);
        check_bit("exc_valid", exc_valid, row.exp_valid);
        check_code("exc_code", exc_code, row.exp_code);
        check_word("exc_pc", exc_pc, row.exp_pc);
        @(posedge clk);  // register file write.
        commit_writes();
        @(negedge clk);
        check_word("rd_data_a", rd_data_a, model_regs[row.rd_a]);
        check_word("rd_data_b", rd_data_b, model_regs[row.rd_b]);
    endtask

    initial begin
        rst_n        <= 1'b0;
        m_master     <= '0;
        m_slave      <= '0;
        master_clear <= 1'b0;
        slave_clear  <= 1'b0;
        master_ena   <= 1'b0;
        slave_ena    <= 1'b0;
        rd_addr_a    <= '0;
        rd_addr_b    <= '0;
        model_m      = '0;
        model_s      = '0;
        for (int i = 0; i < `WB_NREGS; i++) begin
            model_regs[i] = '0;
        end
        build_table();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        check_reset();
        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end
        if (i_dut.i_assert.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("bound assertions failed %0d times", i_dut.i_assert.fail_count);
            $display("TEST FAIL");
            $fatal(1, "assertion failure");
        end
    end

endmodule
